// File: Makefile
# Verilator build for the control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_u2_ctrl
FLIST     ?= u2_ctrl_top.f
FLAGS     ?= --binary --assert --timing

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: rtl/control_regs.sv
////////////////////
// Control pin registers and LED source mux
////////////////////

module control_regs
   import u2_ctrl_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  wb_data_t  set_data_i,
   input  logic      clk_status_i,
   input  logic      serdes_link_up_i,
   input  logic      run_rx_i,
   input  logic      run_tx_i,
   output led_t      leds_o,
   output logic      clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,
   output logic      phy_reset_n_o
);

   // Only the low bits of each byte reach a pin
   logic [4:0] clock_q;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_reset_q;
   led_t       led_sw_q;
   led_t       led_src_q;
   led_t       led_hw;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLOCK:   clock_q     <= set_data_i[4:0];
            SR_SERDES:  serdes_q    <= set_data_i[3:0];
            SR_ADC:     adc_q       <= set_data_i[3:0];
            SR_LED:     led_sw_q    <= set_data_i[7:0];
            SR_PHY:     phy_reset_q <= set_data_i[0];
            SR_LED_SRC: led_src_q   <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_q;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_q;
   assign phy_reset_n_o = ~phy_reset_q;

   // Source bit 1 shows hardware status, 0 shows the software value
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: rtl/pic.sv
////////////////////
// Interrupt controller
// Rising-edge pending bits, mask, write-one-to-clear
////////////////////

module pic
   import u2_ctrl_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   wb_bus_if.slave  bus,
   input  irq_vec_t irq_i,
   output logic     int_o
);

   irq_vec_t          mask_q;
   irq_vec_t          pending_q;
   irq_vec_t          irq_d;
   irq_vec_t          rise;
   irq_vec_t          clr;
   logic              access;
   logic [OFF_W-1:0]  word;

   assign access = bus.cyc & bus.stb & ~bus.ack;
   assign word   = bus.adr[OFF_LSB +: OFF_W];
   assign rise   = irq_i & ~irq_d;
   assign clr    = (access && bus.we && word == PIC_PENDING) ? bus.dat_w[7:0] : '0;

   // Tracks the pins through reset so no edge appears when it ends
   always_ff @(posedge wb_clk) begin
      irq_d <= irq_i;
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         mask_q    <= '0;
         pending_q <= '0;
         bus.ack   <= 1'b0;
         int_o     <= 1'b0;
      end else begin
         bus.ack <= access;
         if (access && bus.we && word == PIC_MASK) begin
            mask_q <= bus.dat_w[7:0];
         end
         // A new edge wins over a clear in the same cycle
         pending_q <= (pending_q & ~clr) | rise;
         int_o     <= |(pending_q & mask_q);
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access) begin
         case (word)
            PIC_MASK:    bus.dat_r <= {24'b0, mask_q};
            PIC_PENDING: bus.dat_r <= {24'b0, pending_q};
            default:     bus.dat_r <= '0;
         endcase
      end
   end

endmodule

// File: rtl/readback_mux.sv
////////////////////
// Readback words and free-running cycle counter
////////////////////

module readback_mux
   import u2_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_bus_if.slave    bus,
   input  irq_vec_t   irq_i,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i
);

   wb_data_t         cycle_count;
   logic             access;
   logic [OFF_W-1:0] word;

   assign access = bus.cyc & bus.stb & ~bus.ack;
   assign word   = bus.adr[OFF_LSB +: OFF_W];

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
         bus.ack     <= 1'b0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
         bus.ack     <= access;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access) begin
         case (word)
            RB_SIM_CLKDIV: bus.dat_r <= {sim_mode_i, 27'b0, clock_divider_i};
            RB_COMPAT:     bus.dat_r <= COMPAT_NUM;
            RB_IRQ:        bus.dat_r <= {24'b0, irq_i};
            RB_CYCLES:     bus.dat_r <= cycle_count;
            default:       bus.dat_r <= '0;
         endcase
      end
   end

endmodule

// File: rtl/settings_bus.sv
////////////////////
// Settings bus
// Turns Wishbone writes into strobe, address and data
////////////////////

module settings_bus
   import u2_ctrl_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   wb_bus_if.slave   bus,
   output logic      set_stb_o,
   output set_addr_t set_addr_o,
   output wb_data_t  set_data_o
);

   logic access;

   assign access = bus.cyc & bus.stb & ~bus.ack;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         bus.ack   <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         bus.ack   <= access;
         set_stb_o <= access & bus.we;
      end
   end

   // Address and data only need to be right while the strobe is high
   always_ff @(posedge wb_clk) begin
      if (access && bus.we) begin
         set_addr_o <= {bus.adr[SET_HI_LSB +: 2], bus.adr[7:OFF_LSB]};
         set_data_o <= bus.dat_w;
      end
   end

   assign bus.dat_r = '0;

endmodule

// File: rtl/simple_timer.sv
////////////////////
// One-shot and periodic interrupt timer
// Programmed through the settings bus
////////////////////

module simple_timer
   import u2_ctrl_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  wb_data_t  set_data_i,
   output logic      onetime_int_o,
   output logic      periodic_int_o
);

   wb_data_t onetime_cnt;
   wb_data_t period;
   wb_data_t periodic_cnt;
   logic     load_onetime;
   logic     load_periodic;

   assign load_onetime  = set_stb_i && (set_addr_i == SR_SIMTIMER);
   assign load_periodic = set_stb_i && (set_addr_i == SR_SIMTIMER + 8'd1);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt  <= '0;
         period       <= '0;
         periodic_cnt <= '0;
      end else begin
         // One-shot counts down to zero and then stays idle
         if (load_onetime) begin
            onetime_cnt <= set_data_i;
         end else if (onetime_cnt != '0) begin
            onetime_cnt <= onetime_cnt - 1'b1;
         end

         if (load_periodic) begin
            period       <= set_data_i;
            periodic_cnt <= set_data_i;
         end else if (period != '0) begin
            periodic_cnt <= (periodic_cnt == 32'd1) ? period : periodic_cnt - 1'b1;
         end
      end
   end

   // Pulse on the last count, N cycles after the load
   assign onetime_int_o  = (onetime_cnt == 32'd1);
   assign periodic_int_o = (period != '0) && (periodic_cnt == 32'd1);

endmodule

// File: rtl/u2_ctrl_pkg.sv
////////////////////
// Control plane package
// Bus widths, address map and setting-register numbers
////////////////////

package u2_ctrl_pkg;

   typedef logic [15:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [7:0]  irq_vec_t;
   typedef logic [7:0]  led_t;

   ////////////////////
   // Address map
   // Slot field selects the slave, word offset sits in bits 5:2
   localparam int SLOT_LSB = 8;
   localparam int SLOT_W   = 4;
   localparam int OFF_LSB  = 2;
   localparam int OFF_W    = 4;
   // Settings address is adr[7:2], top two bits come from adr[13:12]
   // so all 256 registers fit above and below the slot field
   localparam int SET_HI_LSB = 12;

   localparam logic [SLOT_W-1:0] SLOT_READBACK = 4'd5;
   localparam logic [SLOT_W-1:0] SLOT_SETTINGS = 4'd7;
   localparam logic [SLOT_W-1:0] SLOT_PIC      = 4'd8;

   ////////////////////
   // Setting registers
   localparam set_addr_t SR_CLOCK    = 8'd0;
   localparam set_addr_t SR_SERDES   = 8'd1;
   localparam set_addr_t SR_ADC      = 8'd2;
   localparam set_addr_t SR_LED      = 8'd3;
   localparam set_addr_t SR_PHY      = 8'd4;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   localparam set_addr_t SR_SIMTIMER = 8'd198;

   localparam led_t     LED_SRC_RESET = 8'h1E;
   localparam wb_data_t COMPAT_NUM    = 32'd3;

   // Readback words and pic registers
   localparam logic [OFF_W-1:0] RB_SIM_CLKDIV = 4'd9;
   localparam logic [OFF_W-1:0] RB_COMPAT     = 4'd12;
   localparam logic [OFF_W-1:0] RB_IRQ        = 4'd13;
   localparam logic [OFF_W-1:0] RB_CYCLES     = 4'd15;
   localparam logic [OFF_W-1:0] PIC_MASK      = 4'd0;
   localparam logic [OFF_W-1:0] PIC_PENDING   = 4'd1;

   // Interrupt bit positions
   localparam int IRQ_ONETIME     = 0;
   localparam int IRQ_PERIODIC    = 1;
   localparam int IRQ_PHY         = 2;
   localparam int IRQ_CLK_STATUS  = 3;
   localparam int IRQ_SERDES_LINK = 4;

endpackage

// File: rtl/u2_ctrl_top.sv
////////////////////
// Control plane top level
// Decoder, settings, LEDs, timer, pic and readback
////////////////////

module u2_ctrl_top
   import u2_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   input  wb_addr_t   wb_adr_i,
   input  wb_data_t   wb_dat_i,
   output wb_data_t   wb_dat_o,
   output logic       wb_ack_o,
   output logic       wb_err_o,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       run_rx_i,
   input  logic       run_tx_i,
   input  logic       phy_int_n_i,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i,
   output led_t       leds_o,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   output logic       phy_reset_n_o,
   output logic       int_o
);

   wb_bus_if set_bus ();
   wb_bus_if rb_bus ();
   wb_bus_if pic_bus ();

   logic      set_stb;
   set_addr_t set_addr;
   wb_data_t  set_data;
   logic      onetime_int;
   logic      periodic_int;
   irq_vec_t  irq;

   ////////////////////
   // Interrupt vector, PHY pin goes in raw
   assign irq[IRQ_ONETIME]     = onetime_int;
   assign irq[IRQ_PERIODIC]    = periodic_int;
   assign irq[IRQ_PHY]         = phy_int_n_i;
   assign irq[IRQ_CLK_STATUS]  = clk_status_i;
   assign irq[IRQ_SERDES_LINK] = serdes_link_up_i;
   assign irq[$bits(irq_vec_t)-1:IRQ_SERDES_LINK+1] = '0;

   wb_slave_decode u_decode (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .set_bus  (set_bus.master),
      .rb_bus   (rb_bus.master),
      .pic_bus  (pic_bus.master)
   );

   settings_bus u_settings (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .bus        (set_bus.slave),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   control_regs u_ctrl (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .set_stb_i        (set_stb),
      .set_addr_i       (set_addr),
      .set_data_i       (set_data),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .leds_o           (leds_o),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o)
   );

   simple_timer u_timer (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .set_stb_i      (set_stb),
      .set_addr_i     (set_addr),
      .set_data_i     (set_data),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   pic u_pic (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .bus    (pic_bus.slave),
      .irq_i  (irq),
      .int_o  (int_o)
   );

   readback_mux u_readback (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .bus             (rb_bus.slave),
      .irq_i           (irq),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i)
   );

endmodule

// File: rtl/wb_bus_if.sv
////////////////////
// Wishbone slave link between the decoder and one slave
////////////////////

interface wb_bus_if
   import u2_ctrl_pkg::*;
();

   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t adr;
   wb_data_t dat_w;
   wb_data_t dat_r;
   logic     ack;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface

// File: rtl/wb_slave_decode.sv
////////////////////
// Wishbone one-master decoder
// Routes strobes by slot, returns err for unmapped slots
////////////////////

module wb_slave_decode
   import u2_ctrl_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     wb_cyc_i,
   input  logic     wb_stb_i,
   input  logic     wb_we_i,
   input  wb_addr_t wb_adr_i,
   input  wb_data_t wb_dat_i,
   output wb_data_t wb_dat_o,
   output logic     wb_ack_o,
   output logic     wb_err_o,
   wb_bus_if.master set_bus,
   wb_bus_if.master rb_bus,
   wb_bus_if.master pic_bus
);

   logic [SLOT_W-1:0] slot;
   logic              sel_set;
   logic              sel_rb;
   logic              sel_pic;
   logic              err_q;

   assign slot    = wb_adr_i[SLOT_LSB +: SLOT_W];
   assign sel_set = (slot == SLOT_SETTINGS);
   assign sel_rb  = (slot == SLOT_READBACK);
   assign sel_pic = (slot == SLOT_PIC);

   // Shared request lines, stb gated per slot
   assign set_bus.cyc   = wb_cyc_i;
   assign set_bus.we    = wb_we_i;
   assign set_bus.adr   = wb_adr_i;
   assign set_bus.dat_w = wb_dat_i;
   assign set_bus.stb   = wb_stb_i & sel_set;

   assign rb_bus.cyc   = wb_cyc_i;
   assign rb_bus.we    = wb_we_i;
   assign rb_bus.adr   = wb_adr_i;
   assign rb_bus.dat_w = wb_dat_i;
   assign rb_bus.stb   = wb_stb_i & sel_rb;

   assign pic_bus.cyc   = wb_cyc_i;
   assign pic_bus.we    = wb_we_i;
   assign pic_bus.adr   = wb_adr_i;
   assign pic_bus.dat_w = wb_dat_i;
   assign pic_bus.stb   = wb_stb_i & sel_pic;

   assign wb_ack_o = (sel_set & set_bus.ack) | (sel_rb & rb_bus.ack) | (sel_pic & pic_bus.ack);

   always_comb begin
      case (1'b1)
         sel_set: wb_dat_o = set_bus.dat_r;
         sel_rb:  wb_dat_o = rb_bus.dat_r;
         sel_pic: wb_dat_o = pic_bus.dat_r;
         default: wb_dat_o = '0;
      endcase
   end

   // Unmapped slot answers with a one-cycle err
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wb_cyc_i & wb_stb_i & ~(sel_set | sel_rb | sel_pic) & ~err_q;
      end
   end

   assign wb_err_o = err_q;

endmodule

// File: tb/tb_u2_ctrl.sv
////////////////////
// Control plane testbench
// Wishbone master, status pin stimulus, timer and pic sequences
////////////////////

module tb_u2_ctrl
   import u2_ctrl_pkg::*;
;

   localparam int BUS_LIMIT = 20;

   logic       wb_clk;
   logic       wb_rst;
   logic       wb_cyc_i;
   logic       wb_stb_i;
   logic       wb_we_i;
   wb_addr_t   wb_adr_i;
   wb_data_t   wb_dat_i;
   wb_data_t   wb_dat_o;
   logic       wb_ack_o;
   logic       wb_err_o;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       run_rx_i;
   logic       run_tx_i;
   logic       phy_int_n_i;
   logic       sim_mode_i;
   logic [3:0] clock_divider_i;
   led_t       leds_o;
   logic       clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_reset_n_o;
   logic       int_o;

   logic [31:0] lfsr_state = 32'h8859_a0e2;
   logic [31:0] rnd;
   int          n;

   u2_ctrl_top dut0 (.*);

   initial begin
      wb_clk = 1'b0;
      forever #20 wb_clk = ~wb_clk;
   end

   task automatic stop_run(input string why);
      $display("ERROR: %s at %0t", why, $time);
      $display("Result: FAILED");
      $fatal(1, "run stopped");
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < count; i++) begin
         v = {v[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return v;
   endfunction

   function automatic wb_addr_t set_adr(input set_addr_t a);
      return {2'b00, a[7:6], SLOT_SETTINGS, a[5:0], 2'b00};
   endfunction

   function automatic wb_addr_t word_adr(input logic [3:0] slot, input logic [3:0] w);
      return {4'h0, slot, 2'b00, w, 2'b00};
   endfunction

   task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat);
      int k;
      @(posedge wb_clk);
      #2;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      k = 0;
      forever begin
         @(posedge wb_clk);
         #1;
         if (wb_ack_o || wb_err_o) break;
         k++;
         if (k > BUS_LIMIT) stop_run("no ack or err from the bus");
      end
      // Cycle ends on the edge where ack or err is sampled
      @(posedge wb_clk);
      #2;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wait_int(input logic want, input int limit);
      int k;
      for (k = 0; k < limit; k++) begin
         @(posedge wb_clk);
         #1;
         if (int_o == want) break;
      end
      if (int_o != want) stop_run("int_o did not reach the expected level");
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge wb_clk);
      #2;
   endtask

   // Any assertion failure ends the run
   always @(posedge wb_clk) begin
      if (dut0.u_asserts.fail_count != 0) stop_run("assertion failed");
   end

   initial begin
      wb_rst = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      {clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i} = 4'b0000;
      phy_int_n_i = 1'b1;
      sim_mode_i = 1'b1;
      clock_divider_i = 4'hA;
      idle(3);
      wb_rst = 1'b0;
      rnd = take_bits(4);
      {clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i} = rnd[3:0];
      idle(3);

      ////////////////////
      // Setting registers and LEDs
      for (int r = 0; r < 2; r++) begin
         rnd = take_bits(5);
         bus_cycle(1'b1, set_adr(SR_CLOCK), rnd);
         rnd = take_bits(4);
         bus_cycle(1'b1, set_adr(SR_SERDES), rnd);
         rnd = take_bits(4);
         bus_cycle(1'b1, set_adr(SR_ADC), rnd);
         rnd = take_bits(1);
         bus_cycle(1'b1, set_adr(SR_PHY), rnd);
         rnd = take_bits(8);
         bus_cycle(1'b1, set_adr(SR_LED), rnd);
         rnd = take_bits(8);
         bus_cycle(1'b1, set_adr(SR_LED_SRC), rnd);
         for (int i = 0; i < 16; i++) begin
            rnd = take_bits(4);
            {clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i} = rnd[3:0];
            idle(1);
         end
      end

      ////////////////////
      // Readback and unmapped slot
      bus_cycle(1'b0, word_adr(SLOT_READBACK, RB_COMPAT), '0);
      bus_cycle(1'b0, word_adr(SLOT_READBACK, RB_SIM_CLKDIV), '0);
      bus_cycle(1'b0, word_adr(SLOT_READBACK, RB_CYCLES), '0);
      bus_cycle(1'b0, word_adr(SLOT_READBACK, RB_CYCLES), '0);
      bus_cycle(1'b0, word_adr(SLOT_READBACK, RB_IRQ), '0);
      bus_cycle(1'b0, word_adr(4'd3, 4'd0), '0);
      bus_cycle(1'b1, word_adr(4'd3, 4'd1), 32'h1234_5678);

      ////////////////////
      // Timer and pic
      bus_cycle(1'b1, word_adr(SLOT_PIC, PIC_MASK), 32'h1);
      bus_cycle(1'b1, word_adr(SLOT_PIC, PIC_PENDING), 32'hFF);
      rnd = take_bits(6);
      n = int'(rnd[5:0]) + 4;
      bus_cycle(1'b1, set_adr(SR_SIMTIMER), n);
      wait_int(1'b1, n + 8);
      bus_cycle(1'b0, word_adr(SLOT_PIC, PIC_PENDING), '0);
      bus_cycle(1'b0, word_adr(SLOT_PIC, PIC_MASK), '0);
      bus_cycle(1'b1, word_adr(SLOT_PIC, PIC_PENDING), 32'h1);
      wait_int(1'b0, 8);
      bus_cycle(1'b1, set_adr(SR_SIMTIMER + 8'd1), 32'd5);
      idle(26);
      bus_cycle(1'b1, set_adr(SR_SIMTIMER + 8'd1), 32'd0);
      idle(10);

      if (dut0.u_asserts.fail_count != 0) begin
         stop_run("assertion failed");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: tb/u2_ctrl_asserts.sv
////////////////////
// Concurrent checks for the control plane
// Bound into the top level, models built from bus traffic
////////////////////

module u2_ctrl_asserts
   import u2_ctrl_pkg::*;
(
   input logic       wb_clk,
   input logic       wb_rst,
   input logic       wb_cyc_i,
   input logic       wb_stb_i,
   input logic       wb_we_i,
   input wb_addr_t   wb_adr_i,
   input wb_data_t   wb_dat_i,
   input wb_data_t   wb_dat_o,
   input logic       wb_ack_o,
   input logic       wb_err_o,
   input logic       clk_status_i,
   input logic       serdes_link_up_i,
   input logic       run_rx_i,
   input logic       run_tx_i,
   input logic       phy_int_n_i,
   input logic       sim_mode_i,
   input logic [3:0] clock_divider_i,
   input led_t       leds_o,
   input logic       clock_ready_o,
   input logic [1:0] clk_en_o,
   input logic [1:0] clk_sel_o,
   input logic       ser_enable_o,
   input logic       ser_prbsen_o,
   input logic       ser_loopen_o,
   input logic       ser_rx_en_o,
   input logic       adc_oe_a_o,
   input logic       adc_on_a_o,
   input logic       adc_oe_b_o,
   input logic       adc_on_b_o,
   input logic       phy_reset_n_o,
   input logic       int_o,
   input logic       onetime_int,
   input logic       periodic_int
);

   int         fail_count = 0;
   logic [3:0] slot;
   logic [3:0] word;
   set_addr_t  sa;
   logic       first;
   logic       mapped;
   logic       set_wr;
   logic       pic_acc;
   led_t       hw;
   irq_vec_t   irq_v;
   irq_vec_t   irq_p;
   irq_vec_t   clr;
   logic [4:0] clock_m;
   logic [3:0] serdes_m;
   logic [3:0] adc_m;
   logic       phy_m;
   led_t       sw_m;
   led_t       src_m;
   irq_vec_t   pend_m;
   irq_vec_t   mask_m;
   logic       int_m;
   wb_data_t   cyc_m;
   wb_data_t   ot_n;
   wb_data_t   ot_age;
   wb_data_t   per_n;
   wb_data_t   per_age;
   wb_data_t   rb_exp;
   wb_data_t   pic_exp;

   assign slot    = wb_adr_i[11:8];
   assign word    = wb_adr_i[5:2];
   assign sa      = {wb_adr_i[13:12], wb_adr_i[7:2]};
   assign first   = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
   assign mapped  = (slot == 4'd5) || (slot == 4'd7) || (slot == 4'd8);
   // Register updates land on the edge where ack is sampled
   assign set_wr  = wb_ack_o & wb_we_i & (slot == 4'd7);
   assign pic_acc = first & (slot == 4'd8);
   assign hw      = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign irq_v   = {3'b000, serdes_link_up_i, clk_status_i, phy_int_n_i,
                     periodic_int, onetime_int};
   assign clr     = (pic_acc && wb_we_i && word == 4'd1) ? wb_dat_i[7:0] : 8'h00;

   // Read data expected one cycle after the access is seen
   always_ff @(posedge wb_clk) begin
      irq_p <= irq_v;
      case (word)
         4'd9:    rb_exp <= {sim_mode_i, 27'b0, clock_divider_i};
         4'd12:   rb_exp <= 32'd3;
         4'd13:   rb_exp <= {24'b0, irq_v};
         4'd15:   rb_exp <= cyc_m;
         default: rb_exp <= 32'd0;
      endcase
      pic_exp <= {24'b0, (word == 4'd0) ? mask_m : pend_m};
   end

   ////////////////////
   // Reference models
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_m <= '0;
         serdes_m <= '0;
         adc_m <= '0;
         phy_m <= 1'b0;
         sw_m <= '0;
         src_m <= 8'h1E;
         pend_m <= '0;
         mask_m <= '0;
         int_m <= 1'b0;
         cyc_m <= '0;
         ot_n <= '0;
         ot_age <= '0;
         per_n <= '0;
         per_age <= '0;
      end else begin
         cyc_m <= cyc_m + 1;
         if (set_wr && sa == 8'd0) clock_m <= wb_dat_i[4:0];
         if (set_wr && sa == 8'd1) serdes_m <= wb_dat_i[3:0];
         if (set_wr && sa == 8'd2) adc_m <= wb_dat_i[3:0];
         if (set_wr && sa == 8'd3) sw_m <= wb_dat_i[7:0];
         if (set_wr && sa == 8'd4) phy_m <= wb_dat_i[0];
         if (set_wr && sa == 8'd8) src_m <= wb_dat_i[7:0];
         // Pulse expected when the age reaches N-1 before the edge
         if (set_wr && sa == 8'd198) begin
            ot_n <= wb_dat_i;
            ot_age <= '0;
         end else if (ot_age != ot_n) begin
            ot_age <= ot_age + 1;
         end
         if (set_wr && sa == 8'd199) begin
            per_n <= wb_dat_i;
            per_age <= '0;
         end else if (per_n != 0) begin
            per_age <= (per_age == per_n - 1) ? 32'd0 : per_age + 1;
         end
         if (pic_acc && wb_we_i && word == 4'd0) mask_m <= wb_dat_i[7:0];
         pend_m <= (pend_m & ~clr) | (irq_v & ~irq_p);
         int_m <= |(pend_m & mask_m);
      end
   end

   ////////////////////
   // Checks
   a_reset: assert property (@(posedge wb_clk) ($past(wb_rst) && !wb_rst) |->
      (!wb_ack_o && !wb_err_o && !int_o && !clock_ready_o && clk_en_o == 0
       && clk_sel_o == 0 && !ser_enable_o && !ser_prbsen_o && !ser_loopen_o
       && !ser_rx_en_o && !adc_oe_a_o && !adc_on_a_o && !adc_oe_b_o && !adc_on_b_o
       && !onetime_int && !periodic_int && phy_reset_n_o && leds_o == (hw & 8'h1E)))
      else begin
         $error("Outputs not at their reset values after reset at %0t", $time);
         fail_count++;
      end

   a_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (first && mapped) |=> (wb_ack_o && !wb_err_o))
      else begin
         $error("Mapped access at %0t was not acknowledged after one cycle", $time);
         fail_count++;
      end

   a_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (first && !mapped) |=> (wb_err_o && !wb_ack_o && wb_dat_o == 0))
      else begin
         $error("Unmapped access at %0t did not end in err alone", $time);
         fail_count++;
      end

   a_clock: assert property (@(posedge wb_clk) disable iff (wb_rst)
      {clock_ready_o, clk_en_o, clk_sel_o} == clock_m)
      else begin
         $error("MISMATCH %0t {clock_ready_o,clk_en_o,clk_sel_o} exp=%h act=%h", $time,
                clock_m, {clock_ready_o, clk_en_o, clk_sel_o});
         fail_count++;
      end

   a_serdes: assert property (@(posedge wb_clk) disable iff (wb_rst)
      {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} == serdes_m)
      else begin
         $error("MISMATCH %0t {ser_enable_o,ser_prbsen_o,ser_loopen_o,ser_rx_en_o} exp=%h act=%h",
                $time, serdes_m, {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o});
         fail_count++;
      end

   a_adc: assert property (@(posedge wb_clk) disable iff (wb_rst)
      {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} == adc_m)
      else begin
         $error("MISMATCH %0t {adc_oe_a_o,adc_on_a_o,adc_oe_b_o,adc_on_b_o} exp=%h act=%h",
                $time, adc_m, {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
         fail_count++;
      end

   a_phy: assert property (@(posedge wb_clk) disable iff (wb_rst)
      phy_reset_n_o == !phy_m)
      else begin
         $error("MISMATCH %0t phy_reset_n_o exp=%b act=%b", $time, !phy_m, phy_reset_n_o);
         fail_count++;
      end

   a_leds: assert property (@(posedge wb_clk) disable iff (wb_rst)
      leds_o == ((src_m & hw) | (~src_m & sw_m)))
      else begin
         $error("MISMATCH %0t leds_o exp=%h act=%h", $time,
                (src_m & hw) | (~src_m & sw_m), leds_o);
         fail_count++;
      end

   a_rb_read: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wb_ack_o && !wb_we_i && slot == 4'd5) |-> (wb_dat_o == rb_exp))
      else begin
         $error("MISMATCH %0t wb_dat_o readback word %0d exp=%h act=%h", $time, word,
                rb_exp, wb_dat_o);
         fail_count++;
      end

   a_pic_read: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wb_ack_o && !wb_we_i && slot == 4'd8 && word < 4'd2) |-> (wb_dat_o == pic_exp))
      else begin
         $error("MISMATCH %0t wb_dat_o pic word %0d exp=%h act=%h", $time, word,
                pic_exp, wb_dat_o);
         fail_count++;
      end

   a_int: assert property (@(posedge wb_clk) disable iff (wb_rst) int_o == int_m)
      else begin
         $error("MISMATCH %0t int_o exp=%b act=%b", $time, int_m, int_o);
         fail_count++;
      end

   a_onetime: assert property (@(posedge wb_clk) disable iff (wb_rst)
      onetime_int == (ot_n != 0 && ot_age == ot_n - 1))
      else begin
         $error("MISMATCH %0t onetime_int exp=%b act=%b", $time,
                (ot_n != 0 && ot_age == ot_n - 1), onetime_int);
         fail_count++;
      end

   a_periodic: assert property (@(posedge wb_clk) disable iff (wb_rst)
      periodic_int == (per_n != 0 && per_age == per_n - 1))
      else begin
         $error("MISMATCH %0t periodic_int exp=%b act=%b", $time,
                (per_n != 0 && per_age == per_n - 1), periodic_int);
         fail_count++;
      end

endmodule

bind u2_ctrl_top u2_ctrl_asserts u_asserts (.*);

// File: u2_ctrl_top.f
rtl/u2_ctrl_pkg.sv
rtl/wb_bus_if.sv
rtl/wb_slave_decode.sv
rtl/settings_bus.sv
rtl/control_regs.sv
rtl/simple_timer.sv
rtl/pic.sv
rtl/readback_mux.sv
rtl/u2_ctrl_top.sv
tb/u2_ctrl_asserts.sv
tb/tb_u2_ctrl.sv
